// File: cpu.sv
`timescale 1ns/100ps

module cpu (
	input logic clk,
	input logic reset_i,

	// Instruction ROM
	input logic [cpu_pkg::XLEN-1:0] rom_data_i,
	output logic rom_ce_o,
	output logic [cpu_pkg::XLEN-1:0] rom_addr_o,

	// Register file write, visible for observation
	output logic wb_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [cpu_pkg::XLEN-1:0] wb_data_o
);

	cpu_pkg::instr_u if_instr;

	logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr;
	logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr;
	logic [cpu_pkg::XLEN-1:0] rs_data;
	logic [cpu_pkg::XLEN-1:0] rt_data;

	cpu_pkg::alu_op_e id_op;
	logic [cpu_pkg::XLEN-1:0] id_a;
	logic [cpu_pkg::XLEN-1:0] id_b;
	logic id_we;
	logic [cpu_pkg::REG_ADDR_W-1:0] id_waddr;

	logic ex_fwd_we;
	logic [cpu_pkg::REG_ADDR_W-1:0] ex_fwd_addr;
	logic [cpu_pkg::XLEN-1:0] ex_fwd_data;

	// EX/ME content feeds both writeback and forwarding
	logic me_we;
	logic [cpu_pkg::REG_ADDR_W-1:0] me_waddr;
	logic [cpu_pkg::XLEN-1:0] me_data;

	// IF/ID pc is kept in fetch but nothing downstream consumes it
	fetch_stage u_fetch (
		.clk(clk),
		.reset_i(reset_i),
		.rom_data_i(rom_data_i),
		.rom_ce_o(rom_ce_o),
		.rom_addr_o(rom_addr_o),
		.if_pc_o(),
		.if_instr_o(if_instr)
	);

	decode_stage u_decode (
		.clk(clk),
		.reset_i(reset_i),
		.if_instr_i(if_instr),
		.rs_addr_o(rs_addr),
		.rt_addr_o(rt_addr),
		.rs_data_i(rs_data),
		.rt_data_i(rt_data),
		.ex_fwd_we_i(ex_fwd_we),
		.ex_fwd_addr_i(ex_fwd_addr),
		.ex_fwd_data_i(ex_fwd_data),
		.me_fwd_we_i(me_we),
		.me_fwd_addr_i(me_waddr),
		.me_fwd_data_i(me_data),
		.id_op_o(id_op),
		.id_a_o(id_a),
		.id_b_o(id_b),
		.id_we_o(id_we),
		.id_waddr_o(id_waddr)
	);

	execute_stage u_execute (
		.clk(clk),
		.reset_i(reset_i),
		.id_op_i(id_op),
		.id_a_i(id_a),
		.id_b_i(id_b),
		.id_we_i(id_we),
		.id_waddr_i(id_waddr),
		.ex_fwd_we_o(ex_fwd_we),
		.ex_fwd_addr_o(ex_fwd_addr),
		.ex_fwd_data_o(ex_fwd_data),
		.me_we_o(me_we),
		.me_waddr_o(me_waddr),
		.me_data_o(me_data)
	);

	writeback_stage u_writeback (
		.clk(clk),
		.reset_i(reset_i),
		.me_we_i(me_we),
		.me_waddr_i(me_waddr),
		.me_data_i(me_data),
		.rs_addr_i(rs_addr),
		.rt_addr_i(rt_addr),
		.rs_data_o(rs_data),
		.rt_data_o(rt_data),
		.wb_we_o(wb_we_o),
		.wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o)
	);

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

	// Datapath and register file geometry
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [XLEN-1:0] RESET_PC = '0;

	// Major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_XORI = 6'h0e;
	localparam logic [5:0] OP_LUI = 6'h0f;

	// Function codes under OP_SPECIAL
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_NOR = 6'h27;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// One instruction word, seen as R-type or I-type
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} i;
	} instr_u;

	// ALU operations carried from decode to execute
	typedef enum logic [3:0] {
		ALU_NOP = 4'd0,
		ALU_AND = 4'd1,
		ALU_OR = 4'd2,
		ALU_XOR = 4'd3,
		ALU_NOR = 4'd4,
		ALU_ADD = 4'd5,
		ALU_SUB = 4'd6,
		ALU_SLT = 4'd7,
		ALU_SLL = 4'd8,
		ALU_SRL = 4'd9,
		ALU_LUI = 4'd10
	} alu_op_e;

endpackage

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input logic clk,
	input logic reset_i,

	input cpu_pkg::instr_u if_instr_i,

	// Register file read ports
	output logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr_o,
	input logic [cpu_pkg::XLEN-1:0] rs_data_i,
	input logic [cpu_pkg::XLEN-1:0] rt_data_i,

	// Forwarding from the ALU output and from EX/ME
	input logic ex_fwd_we_i,
	input logic [cpu_pkg::REG_ADDR_W-1:0] ex_fwd_addr_i,
	input logic [cpu_pkg::XLEN-1:0] ex_fwd_data_i,
	input logic me_fwd_we_i,
	input logic [cpu_pkg::REG_ADDR_W-1:0] me_fwd_addr_i,
	input logic [cpu_pkg::XLEN-1:0] me_fwd_data_i,

	// ID/EX register
	output cpu_pkg::alu_op_e id_op_o,
	output logic [cpu_pkg::XLEN-1:0] id_a_o,
	output logic [cpu_pkg::XLEN-1:0] id_b_o,
	output logic id_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] id_waddr_o
);

	logic [cpu_pkg::XLEN-1:0] rs_val;
	logic [cpu_pkg::XLEN-1:0] rt_val;
	logic [cpu_pkg::XLEN-1:0] imm_zext;
	logic [cpu_pkg::XLEN-1:0] imm_sext;
	logic [cpu_pkg::XLEN-1:0] shamt_zext;

	cpu_pkg::alu_op_e dec_op;
	logic [cpu_pkg::XLEN-1:0] dec_a;
	logic [cpu_pkg::XLEN-1:0] dec_b;
	logic dec_we;
	logic [cpu_pkg::REG_ADDR_W-1:0] dec_waddr;

	// Priority goes ex, then me, then the register file
	function automatic logic [cpu_pkg::XLEN-1:0] resolve(
		input logic [cpu_pkg::REG_ADDR_W-1:0] addr,
		input logic [cpu_pkg::XLEN-1:0] rf_data
	);
		logic [cpu_pkg::XLEN-1:0] val;
		if (addr == '0) begin
			val = '0;
		end else if (ex_fwd_we_i && ex_fwd_addr_i == addr) begin
			val = ex_fwd_data_i;
		end else if (me_fwd_we_i && me_fwd_addr_i == addr) begin
			val = me_fwd_data_i;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	assign rs_addr_o = if_instr_i.r.rs;
	assign rt_addr_o = if_instr_i.r.rt;

	always_comb begin
		rs_val = resolve(if_instr_i.r.rs, rs_data_i);
		rt_val = resolve(if_instr_i.r.rt, rt_data_i);
	end

	assign imm_zext = {{(cpu_pkg::XLEN-16){1'b0}}, if_instr_i.i.imm};
	assign imm_sext = {{(cpu_pkg::XLEN-16){if_instr_i.i.imm[15]}}, if_instr_i.i.imm};
	assign shamt_zext = {{(cpu_pkg::XLEN-5){1'b0}}, if_instr_i.r.shamt};

	always_comb begin
		dec_op = cpu_pkg::ALU_NOP;
		dec_a = rs_val;
		dec_b = rt_val;
		dec_we = 1'b0;
		dec_waddr = if_instr_i.i.rt;

		case (if_instr_i.r.opcode)
			cpu_pkg::OP_SPECIAL: begin
				dec_we = 1'b1;
				dec_waddr = if_instr_i.r.rd;
				case (if_instr_i.r.funct)
					cpu_pkg::FN_ADDU: dec_op = cpu_pkg::ALU_ADD;
					cpu_pkg::FN_SUBU: dec_op = cpu_pkg::ALU_SUB;
					cpu_pkg::FN_AND: dec_op = cpu_pkg::ALU_AND;
					cpu_pkg::FN_OR: dec_op = cpu_pkg::ALU_OR;
					cpu_pkg::FN_XOR: dec_op = cpu_pkg::ALU_XOR;
					cpu_pkg::FN_NOR: dec_op = cpu_pkg::ALU_NOR;
					cpu_pkg::FN_SLT: dec_op = cpu_pkg::ALU_SLT;
					cpu_pkg::FN_SLL: begin
						// Shifts move rt by shamt
						dec_op = cpu_pkg::ALU_SLL;
						dec_a = rt_val;
						dec_b = shamt_zext;
					end
					cpu_pkg::FN_SRL: begin
						dec_op = cpu_pkg::ALU_SRL;
						dec_a = rt_val;
						dec_b = shamt_zext;
					end
					default: dec_we = 1'b0;
				endcase
			end
			cpu_pkg::OP_ADDIU: begin
				dec_op = cpu_pkg::ALU_ADD;
				dec_b = imm_sext;
				dec_we = 1'b1;
			end
			cpu_pkg::OP_ANDI: begin
				dec_op = cpu_pkg::ALU_AND;
				dec_b = imm_zext;
				dec_we = 1'b1;
			end
			cpu_pkg::OP_ORI: begin
				dec_op = cpu_pkg::ALU_OR;
				dec_b = imm_zext;
				dec_we = 1'b1;
			end
			cpu_pkg::OP_XORI: begin
				dec_op = cpu_pkg::ALU_XOR;
				dec_b = imm_zext;
				dec_we = 1'b1;
			end
			cpu_pkg::OP_LUI: begin
				dec_op = cpu_pkg::ALU_LUI;
				dec_b = imm_zext;
				dec_we = 1'b1;
			end
			default: dec_we = 1'b0;
		endcase

		// Writes to r0 are dropped here so nothing downstream sees them
		if (dec_waddr == '0) begin
			dec_we = 1'b0;
		end
	end

	// ID/EX control
	always_ff @(posedge clk) begin
		if (reset_i) begin
			id_op_o <= cpu_pkg::ALU_NOP;
			id_we_o <= 1'b0;
		end else begin
			id_op_o <= dec_op;
			id_we_o <= dec_we;
		end
	end

	// ID/EX operands and destination
	always_ff @(posedge clk) begin
		id_a_o <= dec_a;
		id_b_o <= dec_b;
		id_waddr_o <= dec_waddr;
	end

endmodule

// File: execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
	input logic clk,
	input logic reset_i,

	// From ID/EX
	input cpu_pkg::alu_op_e id_op_i,
	input logic [cpu_pkg::XLEN-1:0] id_a_i,
	input logic [cpu_pkg::XLEN-1:0] id_b_i,
	input logic id_we_i,
	input logic [cpu_pkg::REG_ADDR_W-1:0] id_waddr_i,

	// Forwarding source straight off the ALU
	output logic ex_fwd_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] ex_fwd_addr_o,
	output logic [cpu_pkg::XLEN-1:0] ex_fwd_data_o,

	// EX/ME register, which is also the memory stage result
	output logic me_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] me_waddr_o,
	output logic [cpu_pkg::XLEN-1:0] me_data_o
);

	localparam int HALF = cpu_pkg::XLEN / 2;

	logic [cpu_pkg::XLEN-1:0] alu_result;
	logic [4:0] shift_amt;

	assign shift_amt = id_b_i[4:0];

	always_comb begin
		case (id_op_i)
			cpu_pkg::ALU_AND: alu_result = id_a_i & id_b_i;
			cpu_pkg::ALU_OR: alu_result = id_a_i | id_b_i;
			cpu_pkg::ALU_XOR: alu_result = id_a_i ^ id_b_i;
			cpu_pkg::ALU_NOR: alu_result = ~(id_a_i | id_b_i);
			// Wraps modulo 2^32
			cpu_pkg::ALU_ADD: alu_result = id_a_i + id_b_i;
			cpu_pkg::ALU_SUB: alu_result = id_a_i - id_b_i;
			cpu_pkg::ALU_SLT: begin
				alu_result = '0;
				alu_result[0] = $signed(id_a_i) < $signed(id_b_i);
			end
			cpu_pkg::ALU_SLL: alu_result = id_a_i << shift_amt;
			cpu_pkg::ALU_SRL: alu_result = id_a_i >> shift_amt;
			// Immediate goes to the upper half
			cpu_pkg::ALU_LUI: alu_result = {id_b_i[HALF-1:0], {HALF{1'b0}}};
			default: alu_result = '0;
		endcase
	end

	assign ex_fwd_we_o = id_we_i;
	assign ex_fwd_addr_o = id_waddr_i;
	assign ex_fwd_data_o = alu_result;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			me_we_o <= 1'b0;
		end else begin
			me_we_o <= id_we_i;
		end
	end

	always_ff @(posedge clk) begin
		me_waddr_o <= id_waddr_i;
		me_data_o <= alu_result;
	end

endmodule

// File: fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
	input logic clk,
	input logic reset_i,

	input logic [cpu_pkg::XLEN-1:0] rom_data_i,
	output logic rom_ce_o,
	output logic [cpu_pkg::XLEN-1:0] rom_addr_o,

	output logic [cpu_pkg::XLEN-1:0] if_pc_o,
	output cpu_pkg::instr_u if_instr_o
);

	logic ce_q;
	logic [cpu_pkg::XLEN-1:0] pc_q;

	// Fetch enable comes up one cycle after reset is released
	always_ff @(posedge clk) begin
		if (reset_i) begin
			ce_q <= 1'b0;
			pc_q <= cpu_pkg::RESET_PC;
		end else begin
			ce_q <= 1'b1;
			if (ce_q) begin
				pc_q <= pc_q + 4;
			end
		end
	end

	assign rom_ce_o = ce_q;
	assign rom_addr_o = pc_q;

	// IF/ID register, holds a NOP until the ROM is enabled
	always_ff @(posedge clk) begin
		if (reset_i || !ce_q) begin
			if_pc_o <= '0;
			if_instr_o.raw <= '0;
		end else begin
			if_pc_o <= pc_q;
			if_instr_o.raw <= rom_data_i;
		end
	end

endmodule

// File: files.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
cpu.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run into sim.log, then decide on the log contents
verilator --binary --assert -Wno-fatal --top-module tb_cpu -f files.f -o sim_cpu \
	&& ./obj_dir/sim_cpu > sim.log 2>&1 \
	&& grep -q "Simulation PASSED" sim.log \
	&& ! grep -q "Simulation FAILED" sim.log \
	|| { echo "Run failed, see sim.log"; exit 1; }

// File: tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;

	logic clk = 1'b0;
	logic reset_i;
	logic [31:0] rom_data_i;
	logic rom_ce_o;
	logic [31:0] rom_addr_o;
	logic wb_we_o;
	logic [4:0] wb_addr_o;
	logic [31:0] wb_data_o;

	logic [31:0] rom [512];
	logic [31:0] shadow [32];
	logic [31:0] seed = 32'h115e_669b;
	logic [31:0] next_pc = '0;
	logic started = 1'b0;
	int prog_len = 0;
	int fetched = 0;
	int cycle = 0;
	int checked = 0;
	int errors = 0;

	// Expected register writes, in retire order
	int exp_cycle[$];
	logic [4:0] exp_addr[$];
	logic [31:0] exp_data[$];

	cpu UUT (
		.clk(clk),
		.reset_i(reset_i),
		.rom_data_i(rom_data_i),
		.rom_ce_o(rom_ce_o),
		.rom_addr_o(rom_addr_o),
		.wb_we_o(wb_we_o),
		.wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o)
	);

	always #4 clk = ~clk;

	// Combinational ROM, word addressed
	assign rom_data_i = rom[rom_addr_o[10:2]];

	function automatic logic [31:0] xorshift32();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic logic [31:0] r_type(input logic [5:0] funct,
		input logic [4:0] rd, rs, rt, shamt);
		cpu_pkg::instr_u ins;
		ins.r.opcode = cpu_pkg::OP_SPECIAL;
		ins.r.rs = rs;
		ins.r.rt = rt;
		ins.r.rd = rd;
		ins.r.shamt = shamt;
		ins.r.funct = funct;
		return ins.raw;
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op,
		input logic [4:0] rt, rs, input logic [15:0] imm);
		cpu_pkg::instr_u ins;
		ins.i.opcode = op;
		ins.i.rs = rs;
		ins.i.rt = rt;
		ins.i.imm = imm;
		return ins.raw;
	endfunction

	// Architectural model, returns {we, addr, data} and updates the shadow registers
	function automatic logic [37:0] ref_exec(input logic [31:0] word);
		cpu_pkg::instr_u ins;
		logic we;
		logic [4:0] dst;
		logic [31:0] s;
		logic [31:0] t;
		logic [31:0] res;
		ins.raw = word;
		s = shadow[ins.r.rs];
		t = shadow[ins.r.rt];
		we = 1'b1;
		dst = ins.i.rt;
		res = '0;
		case (ins.r.opcode)
			cpu_pkg::OP_SPECIAL: begin
				dst = ins.r.rd;
				case (ins.r.funct)
					cpu_pkg::FN_ADDU: res = s + t;
					cpu_pkg::FN_SUBU: res = s - t;
					cpu_pkg::FN_AND: res = s & t;
					cpu_pkg::FN_OR: res = s | t;
					cpu_pkg::FN_XOR: res = s ^ t;
					cpu_pkg::FN_NOR: res = ~(s | t);
					cpu_pkg::FN_SLT: res = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
					cpu_pkg::FN_SLL: res = t << ins.r.shamt;
					cpu_pkg::FN_SRL: res = t >> ins.r.shamt;
					default: we = 1'b0;
				endcase
			end
			cpu_pkg::OP_ADDIU: res = s + {{16{ins.i.imm[15]}}, ins.i.imm};
			cpu_pkg::OP_ANDI: res = s & {16'd0, ins.i.imm};
			cpu_pkg::OP_ORI: res = s | {16'd0, ins.i.imm};
			cpu_pkg::OP_XORI: res = s ^ {16'd0, ins.i.imm};
			cpu_pkg::OP_LUI: res = {ins.i.imm, 16'd0};
			default: we = 1'b0;
		endcase
		if (dst == 5'd0) begin
			we = 1'b0;
		end
		if (we) begin
			shadow[dst] = res;
		end
		return {we, dst, res};
	endfunction

	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [31:0] v;
		logic [31:0] word;
		r = xorshift32();
		v = xorshift32();
		case (v % 14)
			0: word = r_type(cpu_pkg::FN_ADDU, r[14:10], r[4:0], r[9:5], 5'd0);
			1: word = r_type(cpu_pkg::FN_SUBU, r[14:10], r[4:0], r[9:5], 5'd0);
			2: word = r_type(cpu_pkg::FN_AND, r[14:10], r[4:0], r[9:5], 5'd0);
			3: word = r_type(cpu_pkg::FN_OR, r[14:10], r[4:0], r[9:5], 5'd0);
			4: word = r_type(cpu_pkg::FN_XOR, r[14:10], r[4:0], r[9:5], 5'd0);
			5: word = r_type(cpu_pkg::FN_NOR, r[14:10], r[4:0], r[9:5], 5'd0);
			6: word = r_type(cpu_pkg::FN_SLT, r[14:10], r[4:0], r[9:5], 5'd0);
			7: word = r_type(cpu_pkg::FN_SLL, r[14:10], 5'd0, r[9:5], r[19:15]);
			8: word = r_type(cpu_pkg::FN_SRL, r[14:10], 5'd0, r[9:5], r[19:15]);
			9: word = i_type(cpu_pkg::OP_ADDIU, r[9:5], r[4:0], v[31:16]);
			10: word = i_type(cpu_pkg::OP_ANDI, r[9:5], r[4:0], v[31:16]);
			11: word = i_type(cpu_pkg::OP_ORI, r[9:5], r[4:0], v[31:16]);
			12: word = i_type(cpu_pkg::OP_XORI, r[9:5], r[4:0], v[31:16]);
			default: word = i_type(cpu_pkg::OP_LUI, r[9:5], 5'd0, v[31:16]);
		endcase
		return word;
	endfunction

	task automatic emit(input logic [31:0] word);
		rom[prog_len] = word;
		prog_len++;
	endtask

	task automatic load_program();
		for (int k = 0; k < 512; k++) begin
			rom[k] = '0;
		end
		for (int k = 0; k < 32; k++) begin
			shadow[k] = '0;
		end
		// Immediates into independent registers
		emit(i_type(cpu_pkg::OP_ORI, 5'd1, 5'd0, 16'h1234));
		emit(i_type(cpu_pkg::OP_XORI, 5'd2, 5'd0, 16'ha5a5));
		emit(i_type(cpu_pkg::OP_ADDIU, 5'd3, 5'd0, 16'hfffb));
		emit(i_type(cpu_pkg::OP_LUI, 5'd4, 5'd0, 16'hdead));
		emit(i_type(cpu_pkg::OP_ANDI, 5'd5, 5'd1, 16'h0ff0));
		emit(i_type(cpu_pkg::OP_ORI, 5'd6, 5'd0, 16'h8001));
		// r7 producer, consumers at distance 1 to 4
		emit(r_type(cpu_pkg::FN_ADDU, 5'd7, 5'd1, 5'd2, 5'd0));
		emit(r_type(cpu_pkg::FN_SUBU, 5'd8, 5'd7, 5'd3, 5'd0));
		emit(r_type(cpu_pkg::FN_AND, 5'd9, 5'd7, 5'd8, 5'd0));
		emit(r_type(cpu_pkg::FN_OR, 5'd10, 5'd7, 5'd4, 5'd0));
		emit(r_type(cpu_pkg::FN_XOR, 5'd11, 5'd7, 5'd9, 5'd0));
		emit(r_type(cpu_pkg::FN_NOR, 5'd12, 5'd11, 5'd10, 5'd0));
		emit(r_type(cpu_pkg::FN_SLT, 5'd13, 5'd3, 5'd12, 5'd0));
		emit(r_type(cpu_pkg::FN_SLT, 5'd14, 5'd12, 5'd3, 5'd0));
		emit(r_type(cpu_pkg::FN_SLL, 5'd15, 5'd0, 5'd12, 5'd7));
		emit(r_type(cpu_pkg::FN_SRL, 5'd16, 5'd0, 5'd15, 5'd5));
		emit(r_type(cpu_pkg::FN_SUBU, 5'd17, 5'd3, 5'd16, 5'd0));
		// r0 targets and unknown encodings must not write
		emit(i_type(cpu_pkg::OP_ORI, 5'd0, 5'd1, 16'hffff));
		emit(r_type(cpu_pkg::FN_ADDU, 5'd18, 5'd0, 5'd1, 5'd0));
		emit(r_type(cpu_pkg::FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
		emit(r_type(cpu_pkg::FN_OR, 5'd19, 5'd0, 5'd4, 5'd0));
		emit(i_type(6'h3f, 5'd20, 5'd1, 16'h1234));
		emit(r_type(6'h3e, 5'd21, 5'd1, 5'd2, 5'd0));
		emit(r_type(cpu_pkg::FN_ADDU, 5'd22, 5'd20, 5'd21, 5'd0));
		emit(r_type(cpu_pkg::FN_OR, 5'd23, 5'd0, 5'd0, 5'd0));
		for (int k = 0; k < 200; k++) begin
			emit(random_instr());
		end
	endtask

	// Fetch tracking, reference model and writeback compare, mid-cycle
	always @(negedge clk) begin
		logic [37:0] res;
		int e_cycle;
		logic [4:0] e_addr;
		logic [31:0] e_data;
		cycle++;
		if (reset_i) begin
			assert (!rom_ce_o) else begin
				errors++;
				$display("ERROR rom_ce_o: got %h, expected 0 in reset", rom_ce_o);
			end
			assert (!wb_we_o) else begin
				errors++;
				$display("ERROR wb_we_o: got %h, expected 0 in reset", wb_we_o);
			end
		end else begin
			if (started) begin
				assert (rom_ce_o) else begin
					errors++;
					$display("Fetch enable dropped after fetching had started");
				end
			end
			if (rom_ce_o) begin
				started = 1'b1;
				assert (rom_addr_o == next_pc) else begin
					errors++;
					$display("ERROR rom_addr_o: got %h, expected %h", rom_addr_o, next_pc);
				end
				next_pc = next_pc + 32'd4;
				fetched++;
				res = ref_exec(rom_data_i);
				if (res[37]) begin
					exp_cycle.push_back(cycle + 4);
					exp_addr.push_back(res[36:32]);
					exp_data.push_back(res[31:0]);
				end
			end
			if (wb_we_o) begin
				if (exp_addr.size() == 0) begin
					errors++;
					$display("Unexpected register write to r%0d", wb_addr_o);
				end else begin
					e_cycle = exp_cycle.pop_front();
					e_addr = exp_addr.pop_front();
					e_data = exp_data.pop_front();
					checked++;
					assert (cycle == e_cycle) else begin
						errors++;
						$display("Write to r%0d came in cycle %0d instead of cycle %0d",
							wb_addr_o, cycle, e_cycle);
					end
					assert (wb_addr_o == e_addr) else begin
						errors++;
						$display("ERROR wb_addr_o: got %h, expected %h", wb_addr_o, e_addr);
					end
					assert (wb_data_o == e_data) else begin
						errors++;
						$display("ERROR wb_data_o: got %h, expected %h", wb_data_o, e_data);
					end
				end
			end
		end
	end

	initial begin
		int wait_cnt;
		reset_i = 1'b1;
		load_program();
		repeat (5) @(posedge clk);
		#1 reset_i = 1'b0;

		// Fetch should come up in the first cycle after reset
		wait_cnt = 0;
		while (!rom_ce_o && wait_cnt < 10) begin
			@(negedge clk);
			wait_cnt++;
		end
		assert (rom_ce_o && wait_cnt == 2) else begin
			errors++;
			$display("Fetch did not start in the first cycle after reset");
		end

		// Run past the program so trailing NOPs drain the pipeline
		wait_cnt = 0;
		while (fetched < prog_len + 8 && wait_cnt < 2000) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (fetched < prog_len + 8) begin
			errors++;
			$display("Timed out before the program was fetched");
		end
		assert (exp_addr.size() == 0) else begin
			errors++;
			$display("%0d expected register writes never appeared", exp_addr.size());
		end

		$display("Writes checked: %0d, errors: %0d", checked, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage (
	input logic clk,
	input logic reset_i,

	// From EX/ME
	input logic me_we_i,
	input logic [cpu_pkg::REG_ADDR_W-1:0] me_waddr_i,
	input logic [cpu_pkg::XLEN-1:0] me_data_i,

	// Read ports for decode
	input logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr_i,
	input logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr_i,
	output logic [cpu_pkg::XLEN-1:0] rs_data_o,
	output logic [cpu_pkg::XLEN-1:0] rt_data_o,

	// ME/WB register holding the write that retires this cycle
	output logic wb_we_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr_o,
	output logic [cpu_pkg::XLEN-1:0] wb_data_o
);

	localparam int NUM_REGS = 2 ** cpu_pkg::REG_ADDR_W;

	logic [cpu_pkg::XLEN-1:0] regs [NUM_REGS];

	// Current write passes through to a matching read
	function automatic logic [cpu_pkg::XLEN-1:0] read_reg(
		input logic [cpu_pkg::REG_ADDR_W-1:0] addr
	);
		logic [cpu_pkg::XLEN-1:0] val;
		if (addr == '0) begin
			val = '0;
		end else if (wb_we_o && wb_addr_o == addr) begin
			val = wb_data_o;
		end else begin
			val = regs[addr];
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_we_o <= 1'b0;
		end else begin
			wb_we_o <= me_we_i;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr_o <= me_waddr_i;
		wb_data_o <= me_data_i;
	end

	// Register array is cleared while in reset
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int k = 0; k < NUM_REGS; k++) begin
				regs[k] <= '0;
			end
		end else if (wb_we_o && wb_addr_o != '0) begin
			regs[wb_addr_o] <= wb_data_o;
		end
	end

	always_comb begin
		rs_data_o = read_reg(rs_addr_i);
		rt_data_o = read_reg(rt_addr_i);
	end

endmodule
